// ==== Bender.yml ====
package:
  name: mem_console

sources:
  - include_dirs:
      - include
    files:
      - hdl/mem_types_pkg.sv
      - hdl/console_pkg.sv
      - hdl/init_bram.sv
      - hdl/credit_fifo.sv
      - hdl/credit_counter.sv
      - hdl/console_ctrl.sv
      - hdl/mem_console_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/console_checker.sv
      - verification/console_tb.sv

// ==== filelist.f ====
+incdir+include
hdl/mem_types_pkg.sv
hdl/console_pkg.sv
hdl/init_bram.sv
hdl/credit_fifo.sv
hdl/credit_counter.sv
hdl/console_ctrl.sv
hdl/mem_console_top.sv
verification/console_checker.sv
verification/console_tb.sv

// ==== hdl/console_ctrl.sv ====
`timescale 1ns/1ns

module console_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,
    input  console_pkg::cmd_t    head,
    input  logic                 not_empty,
    output logic                 pop,
    input  logic                 rsp_credit_ok,
    output logic                 rsp_sent,
    output logic                 rsp_valid,
    output console_pkg::rsp_t    rsp,
    output logic                 wr_en,
    output mem_types_pkg::addr_t wr_addr,
    output mem_types_pkg::word_t wr_data,
    output logic                 rd_en,
    output mem_types_pkg::addr_t rd_addr,
    input  mem_types_pkg::word_t rd_data
);

    import mem_types_pkg::*;
    import console_pkg::*;

    localparam int ADDR_W = $bits(addr_t);
    localparam int DATA_W = $bits(word_t);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        READ_WAIT,
        RESPOND
    } state_e;

    state_e state;
    state_e state_nxt;
    cmd_t   cmd_q;
    addr_t  addr_reg;
    word_t  data_reg;
    logic   show_now;
    logic   in_rsp;

    // address and data shows need no RAM access
    assign show_now = (state == EXEC) && (cmd_q.op == SHOW) && (cmd_q.sel != SHOW_MEM);
    assign in_rsp   = show_now || (state == READ_WAIT) || (state == RESPOND);

    assign pop       = (state == IDLE) && not_empty;
    assign rsp_valid = in_rsp && rsp_credit_ok;
    assign rsp_sent  = rsp_valid;

    assign wr_en   = (state == EXEC) && (cmd_q.op == WRITE);
    assign wr_addr = addr_reg;
    assign wr_data = data_reg;
    assign rd_en   = (state == EXEC) && (cmd_q.op == SHOW) && (cmd_q.sel == SHOW_MEM);
    assign rd_addr = addr_reg;

    always_comb begin
        rsp.sel = cmd_q.sel;
        case (cmd_q.sel)
            SHOW_MEM:  rsp.value = rd_data;
            SHOW_ADDR: rsp.value = DATA_W'(addr_reg);
            SHOW_DATA: rsp.value = data_reg;
            default:   rsp.value = '0;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (not_empty) state_nxt = EXEC;
            EXEC: begin
                if (cmd_q.op != SHOW) begin
                    state_nxt = IDLE;
                end else if (cmd_q.sel == SHOW_MEM) begin
                    state_nxt = READ_WAIT;
                end else begin
                    state_nxt = rsp_credit_ok ? IDLE : RESPOND;
                end
            end
            // stall here until the sink has room
            READ_WAIT, RESPOND: state_nxt = rsp_credit_ok ? IDLE : RESPOND;
            default: state_nxt = IDLE;
        endcase
    end

    // command word latched on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            cmd_q <= head;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            addr_reg <= '0;
            data_reg <= '0;
        end else begin
            state <= state_nxt;
            if (state == EXEC) begin
                case (cmd_q.op)
                    SET_ADDR: addr_reg <= cmd_q.operand[ADDR_W-1:0];
                    LOAD_LO:  data_reg[7:0] <= cmd_q.operand[7:0];
                    LOAD_HI:  data_reg[DATA_W-1:8] <= cmd_q.operand[7:0];
                    default:  ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/console_pkg.sv ====
package console_pkg;

    // opcode of one console command
    typedef enum logic [2:0] {
        SET_ADDR = 3'd0,
        LOAD_LO  = 3'd1,
        LOAD_HI  = 3'd2,
        WRITE    = 3'd3,
        SHOW     = 3'd4
    } cmd_op_e;

    typedef enum logic [1:0] {
        SHOW_MEM  = 2'd0,
        SHOW_ADDR = 2'd1,
        SHOW_DATA = 2'd2
    } show_sel_e;

    // sel only matters for SHOW
    typedef struct packed {
        cmd_op_e              op;
        show_sel_e            sel;
        mem_types_pkg::word_t operand;
    } cmd_t;

    typedef struct packed {
        show_sel_e            sel;
        mem_types_pkg::word_t value;
    } rsp_t;

endpackage

// ==== hdl/credit_counter.sv ====
`timescale 1ns/1ns

`include "console_config.svh"

module credit_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic consume,
    input  logic restore,
    output logic available
);

    localparam int CNT_W = $clog2(`CONSOLE_RSP_CREDITS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= CNT_W'(`CONSOLE_RSP_CREDITS);
        end else begin
            // consume and restore together leave the count as it is
            case ({consume, restore})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign available = (count != '0);

endmodule

// ==== hdl/credit_fifo.sv ====
`timescale 1ns/1ns

`include "console_config.svh"

module credit_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);

    localparam int DEPTH = `CONSOLE_CMD_DEPTH;
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    // one extra bit tells a full ring from an empty one
    localparam int PTR_W = IDX_W + 1;

    payload_t           slots [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;

    // the source only pushes with a credit in hand, so no overflow check
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr[IDX_W-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // one slot freed, hand one credit back
            credit <= pop;
        end
    end

    assign not_empty = (wr_ptr != rd_ptr);
    assign head      = slots[rd_ptr[IDX_W-1:0]];

endmodule

// ==== hdl/init_bram.sv ====
`timescale 1ns/1ns

`include "console_config.svh"

module init_bram (
    input  logic                 clk,
    input  logic                 wr_en,
    input  mem_types_pkg::addr_t wr_addr,
    input  mem_types_pkg::word_t wr_data,
    input  logic                 rd_en,
    input  mem_types_pkg::addr_t rd_addr,
    output mem_types_pkg::word_t rd_data
);

    import mem_types_pkg::*;

    word_t mem [`CONSOLE_MEM_DEPTH];

    // seed the low words, clear the rest
    initial begin
        for (int i = 0; i < `CONSOLE_MEM_DEPTH; i++) begin
            if (i < INIT_LEN) begin
                mem[i] = init_pattern[i];
            end else begin
                mem[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read word is held while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hdl/mem_console_top.sv ====
`timescale 1ns/1ns

module mem_console_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  console_pkg::cmd_t cmd,
    output logic              cmd_credit,
    output logic              rsp_valid,
    output console_pkg::rsp_t rsp,
    input  logic              rsp_credit
);

    import mem_types_pkg::*;
    import console_pkg::*;

    cmd_t  head;
    logic  not_empty;
    logic  pop;
    logic  rsp_credit_ok;
    logic  rsp_sent;
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;
    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;

    credit_fifo #(
        .payload_t(cmd_t)
    ) u_cmd_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (cmd_valid),
        .push_data (cmd),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .credit    (cmd_credit)
    );

    // response credits toward the sink
    credit_counter u_rsp_credits (
        .clk       (clk),
        .arst_n    (arst_n),
        .consume   (rsp_sent),
        .restore   (rsp_credit),
        .available (rsp_credit_ok)
    );

    console_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .head          (head),
        .not_empty     (not_empty),
        .pop           (pop),
        .rsp_credit_ok (rsp_credit_ok),
        .rsp_sent      (rsp_sent),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    // both RAM ports run on the single system clock
    init_bram u_bram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== hdl/mem_types_pkg.sv ====
`include "console_config.svh"

package mem_types_pkg;

    // memory word and word address
    typedef logic [`CONSOLE_DATA_W-1:0] word_t;
    typedef logic [$clog2(`CONSOLE_MEM_DEPTH)-1:0] addr_t;

    // startup contents for the lowest addresses, everything above is zero
    localparam int INIT_LEN = 10;

    typedef word_t init_pattern_t [INIT_LEN];

    localparam init_pattern_t init_pattern = '{
        16'h0001,
        16'hAAAA,
        16'h5555,
        16'hFFFF,
        16'hF0F0,
        16'h0F0F,
        16'hCCCC,
        16'h3333,
        16'h0002,
        16'h0004
    };

endpackage

// ==== include/console_config.svh ====
`ifndef CONSOLE_CONFIG_SVH
`define CONSOLE_CONFIG_SVH

// number of words in the block RAM
`define CONSOLE_MEM_DEPTH 1024

// width of a memory word and of the data register
`define CONSOLE_DATA_W 16

// command queue slots, also the credits the source starts with
`define CONSOLE_CMD_DEPTH 4

// response credits owned by the console at reset
`define CONSOLE_RSP_CREDITS 2

`endif

// ==== verification/console_checker.sv ====
`timescale 1ns/1ns

`include "console_config.svh"

module console_checker (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  console_pkg::cmd_t cmd,
    input  logic              cmd_credit,
    input  logic              rsp_valid,
    input  console_pkg::rsp_t rsp,
    input  logic              rsp_credit,
    input  int                test_id,
    input  logic              run_done,
    output int                error_count,
    output int                pending_rsp,
    output int                cmd_outstanding
);

    import mem_types_pkg::*;
    import console_pkg::*;

    // reference copy of RAM, address register and data register
    word_t ref_mem [`CONSOLE_MEM_DEPTH];
    addr_t ref_addr;
    word_t ref_data;
    rsp_t  exp_q [$];
    int    exp_test [$];
    int    rsp_inflight;

    initial begin
        error_count     = 0;
        pending_rsp     = 0;
        cmd_outstanding = 0;
        rsp_inflight    = 0;
        ref_addr        = '0;
        ref_data        = '0;
        for (int i = 0; i < `CONSOLE_MEM_DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        ref_mem[0] = 16'h0001;
        ref_mem[1] = 16'hAAAA;
        ref_mem[2] = 16'h5555;
        ref_mem[3] = 16'hFFFF;
        ref_mem[4] = 16'hF0F0;
        ref_mem[5] = 16'h0F0F;
        ref_mem[6] = 16'hCCCC;
        ref_mem[7] = 16'h3333;
        ref_mem[8] = 16'h0002;
        ref_mem[9] = 16'h0004;
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "startup_pattern";
            2:       return "set_addr";
            3:       return "load_data";
            4:       return "write_read";
            5:       return "random_stream";
            default: return "unnamed";
        endcase
    endfunction

    // applies one command to the model, returns 1 when a response is due
    function automatic bit ref_step(input cmd_t c, output word_t value);
        value = '0;
        case (c.op)
            SET_ADDR: ref_addr = c.operand[$bits(addr_t)-1:0];
            LOAD_LO:  ref_data[7:0] = c.operand[7:0];
            LOAD_HI:  ref_data[15:8] = c.operand[7:0];
            WRITE:    ref_mem[ref_addr] = ref_data;
            SHOW: begin
                case (c.sel)
                    SHOW_MEM:  value = ref_mem[ref_addr];
                    SHOW_ADDR: value = word_t'(ref_addr);
                    SHOW_DATA: value = ref_data;
                    default:   value = '0;
                endcase
                return 1'b1;
            end
            default: ;
        endcase
        return 1'b0;
    endfunction

    always @(posedge clk) begin : watch
        word_t value;
        rsp_t  expected;
        int    id;
        if (arst_n) begin
            if (cmd_credit) begin
                if (cmd_outstanding == 0) begin
                    error_count++;
                    $display("command credit returned with no command outstanding");
                end else begin
                    cmd_outstanding--;
                end
            end
            if (cmd_valid) begin
                cmd_outstanding++;
                if (cmd_outstanding > `CONSOLE_CMD_DEPTH) begin
                    error_count++;
                    $display("command sent while the source had no command credit");
                end
                if (ref_step(cmd, value)) begin
                    expected.sel   = cmd.sel;
                    expected.value = value;
                    exp_q.push_back(expected);
                    exp_test.push_back(test_id);
                end
            end
            // the count seen by this response excludes credits returned in the same cycle
            if (rsp_valid) begin
                if (rsp_inflight >= `CONSOLE_RSP_CREDITS) begin
                    error_count++;
                    $display("response sent after the response credits were used up");
                end
                rsp_inflight++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("unexpected response %h with no show command waiting", rsp);
                end else begin
                    expected = exp_q.pop_front();
                    id       = exp_test.pop_front();
                    if (rsp !== expected) begin
                        error_count++;
                        $display("mismatch %s: expected %h actual %h",
                                 test_name(id), expected, rsp);
                    end
                end
            end
            if (rsp_credit) begin
                rsp_inflight--;
            end
            pending_rsp = exp_q.size();
        end
    end

    always @(posedge run_done) begin
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        if (cmd_outstanding != 0) begin
            error_count++;
            $display("%0d accepted commands never returned a credit", cmd_outstanding);
        end
    end

endmodule

// ==== verification/console_tb.sv ====
`timescale 1ns/1ns

`include "console_config.svh"

module console_tb;

    import mem_types_pkg::*;
    import console_pkg::*;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_CMDS  = 300;
    localparam int DRAIN_CYCLES = 40 * (`CONSOLE_CMD_DEPTH + 1);

    logic   clk;
    logic   arst_n;
    logic   cmd_valid;
    cmd_t   cmd;
    logic   cmd_credit;
    logic   rsp_valid;
    rsp_t   rsp;
    logic   rsp_credit;
    logic   run_done;
    cmd_t   src_q [$];
    int     src_credits;
    int     sink_wait [$];
    int     planned;
    int     cycles;
    int     test_id;
    int     checker_errors;
    int     pending_rsp;
    int     cmd_outstanding;
    integer seed;

    mem_console_top u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    console_checker u_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .cmd_credit      (cmd_credit),
        .rsp_valid       (rsp_valid),
        .rsp             (rsp),
        .rsp_credit      (rsp_credit),
        .test_id         (test_id),
        .run_done        (run_done),
        .error_count     (checker_errors),
        .pending_rsp     (pending_rsp),
        .cmd_outstanding (cmd_outstanding)
    );

    always #(CLK_HALF) clk = ~clk;

    // command source spends one credit per command sent
    always @(posedge clk) begin
        if (cmd_credit) begin
            src_credits++;
        end
        if (arst_n && src_q.size() > 0 && src_credits > 0) begin
            cmd       <= src_q.pop_front();
            cmd_valid <= 1'b1;
            src_credits--;
        end else begin
            cmd_valid <= 1'b0;
        end
    end

    // sink hands back one credit per response after 0 to 5 cycles
    always @(posedge clk) begin : sink
        int idx;
        if (rsp_valid) begin
            sink_wait.push_back($unsigned($random(seed)) % 6);
        end
        idx = -1;
        for (int i = 0; i < sink_wait.size(); i++) begin
            if (idx < 0 && sink_wait[i] <= 0) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            sink_wait.delete(idx);
            rsp_credit <= 1'b1;
        end else begin
            rsp_credit <= 1'b0;
        end
        for (int i = 0; i < sink_wait.size(); i++) begin
            sink_wait[i]--;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * planned + 200) begin
            $display("timeout after %0d cycles, the console stopped making progress", cycles);
            $display("total errors: %0d", checker_errors + 1);
            $display("Errors found");
            $finish;
        end
    end

    task automatic push_cmd(input cmd_op_e op, input show_sel_e sel, input word_t operand);
        cmd_t c;
        c.op      = op;
        c.sel     = sel;
        c.operand = operand;
        src_q.push_back(c);
        planned++;
    endtask

    task automatic show_mem_at(input int addr);
        push_cmd(SET_ADDR, SHOW_MEM, word_t'(addr));
        push_cmd(SHOW, SHOW_MEM, '0);
    endtask

    task automatic show_addr_of(input word_t operand);
        push_cmd(SET_ADDR, SHOW_MEM, operand);
        push_cmd(SHOW, SHOW_ADDR, '0);
    endtask

    // all commands sent, then a bounded time to answer and credit back
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (src_q.size() != 0 || cmd_valid) begin
            @(negedge clk);
        end
        while ((pending_rsp != 0 || cmd_outstanding != 0 || sink_wait.size() != 0 ||
                rsp_credit) && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        cmd_op_e op;
        word_t   opnd;
        seed        = 65668;
        clk         = 1'b0;
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        rsp_credit  = 1'b0;
        run_done    = 1'b0;
        src_credits = `CONSOLE_CMD_DEPTH;
        planned     = 0;
        cycles      = 0;
        test_id     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        test_id = 1;
        for (int a = 0; a < 10; a++) begin
            show_mem_at(a);
        end
        show_mem_at(500);
        wait_idle();

        // upper operand bits must be dropped
        test_id = 2;
        show_addr_of(16'hFFFF);
        show_addr_of(16'h1234);
        show_addr_of(16'h8155);
        show_addr_of(16'h0000);
        wait_idle();

        test_id = 3;
        push_cmd(LOAD_LO, SHOW_MEM, 16'hFFA5);
        push_cmd(SHOW, SHOW_DATA, '0);
        push_cmd(LOAD_HI, SHOW_MEM, 16'h773C);
        push_cmd(SHOW, SHOW_DATA, '0);
        push_cmd(LOAD_LO, SHOW_MEM, 16'h0011);
        push_cmd(SHOW, SHOW_DATA, '0);
        wait_idle();

        test_id = 4;
        push_cmd(SET_ADDR, SHOW_MEM, 16'd20);
        push_cmd(LOAD_LO, SHOW_MEM, 16'h00EF);
        push_cmd(LOAD_HI, SHOW_MEM, 16'h00BE);
        push_cmd(WRITE, SHOW_MEM, '0);
        push_cmd(SHOW, SHOW_MEM, '0);
        show_mem_at(19);
        show_mem_at(21);
        push_cmd(SET_ADDR, SHOW_MEM, 16'd3);
        push_cmd(WRITE, SHOW_MEM, '0);
        show_mem_at(2);
        show_mem_at(3);
        show_mem_at(4);
        show_mem_at(20);
        wait_idle();

        test_id = 5;
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            op   = cmd_op_e'($unsigned($random(seed)) % 5);
            opnd = word_t'($random(seed));
            // half the address loads stay low so writes get read back
            if (op == SET_ADDR && opnd[15]) begin
                opnd[9:5] = '0;
            end
            push_cmd(op, show_sel_e'($unsigned($random(seed)) % 3), opnd);
        end
        wait_idle();

        run_done = 1'b1;
        @(negedge clk);
        $display("total errors: %0d", checker_errors);
        if (checker_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
